/* hdl/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    // Step encoding of the multicycle sequence
    localparam int stepW = 4;

    localparam logic [stepW-1:0] stepFetch       = 4'd0;
    localparam logic [stepW-1:0] stepPcUpdate    = 4'd1;
    localparam logic [stepW-1:0] stepIrLoad      = 4'd2;
    localparam logic [stepW-1:0] stepRegRead     = 4'd3;
    localparam logic [stepW-1:0] stepDispatch    = 4'd4;
    localparam logic [stepW-1:0] stepExecAlu     = 4'd5;
    localparam logic [stepW-1:0] stepWriteAlu    = 4'd6;
    localparam logic [stepW-1:0] stepShiftLoad   = 4'd7;
    localparam logic [stepW-1:0] stepShiftRun    = 4'd8;
    localparam logic [stepW-1:0] stepShiftSettle = 4'd9;
    localparam logic [stepW-1:0] stepWriteShift  = 4'd10;
    localparam logic [stepW-1:0] stepRetire      = 4'd11;

    // Instruction fields
    localparam int fieldW = 6;

    localparam logic [fieldW-1:0] opcodeRFormat = 6'h00;
    localparam logic [fieldW-1:0] opcodeAddi    = 6'h08;

    localparam logic [fieldW-1:0] functAdd  = 6'h20;
    localparam logic [fieldW-1:0] functSub  = 6'h22;
    localparam logic [fieldW-1:0] functAnd  = 6'h24;
    localparam logic [fieldW-1:0] functSll  = 6'h00;
    localparam logic [fieldW-1:0] functSrl  = 6'h02;
    localparam logic [fieldW-1:0] functSra  = 6'h03;
    localparam logic [fieldW-1:0] functSllv = 6'h04;
    localparam logic [fieldW-1:0] functSrav = 6'h07;

    // Execute path picked at dispatch
    localparam int pathW = 2;

    localparam logic [pathW-1:0] pathNone  = 2'd0;
    localparam logic [pathW-1:0] pathAlu   = 2'd1;
    localparam logic [pathW-1:0] pathShift = 2'd2;

    // ALU operation
    localparam int aluOpW = 3;

    localparam logic [aluOpW-1:0] aluOpNone = 3'd0;
    localparam logic [aluOpW-1:0] aluOpAdd  = 3'd1;
    localparam logic [aluOpW-1:0] aluOpSub  = 3'd2;
    localparam logic [aluOpW-1:0] aluOpAnd  = 3'd3;

    // Shift register commands
    localparam int shiftCtrlW = 3;

    localparam logic [shiftCtrlW-1:0] shiftNone       = 3'd0;
    localparam logic [shiftCtrlW-1:0] shiftLoad       = 3'd1;
    localparam logic [shiftCtrlW-1:0] shiftLeft       = 3'd2;
    localparam logic [shiftCtrlW-1:0] shiftRightLogic = 3'd3;
    localparam logic [shiftCtrlW-1:0] shiftRightArith = 3'd4;

    // ALU B operand mux
    localparam int aluSrcBW = 3;

    localparam logic [aluSrcBW-1:0] srcBRegB   = 3'd0;
    localparam logic [aluSrcBW-1:0] srcBFour   = 3'd1;
    localparam logic [aluSrcBW-1:0] srcBImm    = 3'd3;
    localparam logic [aluSrcBW-1:0] srcBBranch = 3'd4;

    // ALU A operand mux
    localparam int aluSrcAW = 2;

    localparam logic [aluSrcAW-1:0] srcAPc   = 2'd0;
    localparam logic [aluSrcAW-1:0] srcARegA = 2'd1;

    // Destination register mux
    localparam int regDstW = 2;

    localparam logic [regDstW-1:0] dstRt = 2'd0;
    localparam logic [regDstW-1:0] dstRd = 2'd3;

    // Write-back data mux
    localparam int memToRegW = 3;

    localparam logic [memToRegW-1:0] wbAluOut = 3'd0;
    localparam logic [memToRegW-1:0] wbShift  = 3'd2;

    // Shift amount source
    localparam int shamtSelW = 2;

    localparam logic [shamtSelW-1:0] shamtField = 2'd0;
    localparam logic [shamtSelW-1:0] shamtRegB  = 2'd3;

endpackage

`default_nettype wire

/* hdl/instrDecoder.sv */
`default_nettype none

module instrDecoder (
    input  logic [ctrlPkg::fieldW-1:0]     opcode,
    input  logic [ctrlPkg::fieldW-1:0]     funct,
    output logic [ctrlPkg::pathW-1:0]      execPath,
    output logic [ctrlPkg::aluOpW-1:0]     aluOp,
    output logic                           useImm,
    output logic [ctrlPkg::shiftCtrlW-1:0] shiftKind,
    output logic                           shiftByReg
);

    import ctrlPkg::*;

    always_comb begin
        execPath   = pathNone;
        aluOp      = aluOpNone;
        useImm     = 1'b0;
        shiftKind  = shiftNone;
        shiftByReg = 1'b0;

        case (opcode)
            opcodeRFormat: begin
                // R format is told apart by funct
                case (funct)
                    functAdd: begin
                        execPath = pathAlu;
                        aluOp    = aluOpAdd;
                    end
                    functSub: begin
                        execPath = pathAlu;
                        aluOp    = aluOpSub;
                    end
                    functAnd: begin
                        execPath = pathAlu;
                        aluOp    = aluOpAnd;
                    end
                    functSll: begin
                        execPath  = pathShift;
                        shiftKind = shiftLeft;
                    end
                    functSrl: begin
                        execPath  = pathShift;
                        shiftKind = shiftRightLogic;
                    end
                    functSra: begin
                        execPath  = pathShift;
                        shiftKind = shiftRightArith;
                    end
                    functSllv: begin
                        execPath   = pathShift;
                        shiftKind  = shiftLeft;
                        shiftByReg = 1'b1;
                    end
                    functSrav: begin
                        execPath   = pathShift;
                        shiftKind  = shiftRightArith;
                        shiftByReg = 1'b1;
                    end
                    default: begin
                        execPath = pathNone;
                    end
                endcase
            end
            opcodeAddi: begin
                execPath = pathAlu;
                aluOp    = aluOpAdd;
                useImm   = 1'b1;
            end
            default: begin
                execPath = pathNone;
            end
        endcase
    end

    // Shift and ALU paths never drive the ALU together
    always_comb begin
        assert (execPath != pathShift || aluOp == aluOpNone)
            else $error("shift path decoded with ALU op %0d", aluOp);
    end

endmodule

`default_nettype wire

/* hdl/stepSequencer.sv */
`default_nettype none

module stepSequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [ctrlPkg::pathW-1:0] execPath,
    output logic [ctrlPkg::stepW-1:0] step
);

    import ctrlPkg::*;

    logic [stepW-1:0] nextStep;

    always_comb begin
        nextStep = stepFetch;
        case (step)
            stepFetch:       nextStep = stepPcUpdate;
            stepPcUpdate:    nextStep = stepIrLoad;
            stepIrLoad:      nextStep = stepRegRead;
            stepRegRead:     nextStep = stepDispatch;
            stepDispatch: begin
                // Unsupported instructions skip straight to retire
                case (execPath)
                    pathAlu:   nextStep = stepExecAlu;
                    pathShift: nextStep = stepShiftLoad;
                    default:   nextStep = stepRetire;
                endcase
            end
            stepExecAlu:     nextStep = stepWriteAlu;
            stepWriteAlu:    nextStep = stepRetire;
            stepShiftLoad:   nextStep = stepShiftRun;
            stepShiftRun:    nextStep = stepShiftSettle;
            stepShiftSettle: nextStep = stepWriteShift;
            stepWriteShift:  nextStep = stepRetire;
            stepRetire:      nextStep = stepFetch;
            default:         nextStep = stepFetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= stepFetch;
        end else begin
            step <= nextStep;
        end
    end

    // Only the twelve defined codes ever appear
    assert property (@(posedge clk) disable iff (reset)
        step <= stepRetire)
        else $error("undefined step code %0d", step);

    // Each instruction ends with exactly one delay step
    assert property (@(posedge clk) disable iff (reset)
        step == stepRetire |=> step == stepFetch)
        else $error("retire not followed by fetch");

endmodule

`default_nettype wire

/* hdl/controlWordGen.sv */
`default_nettype none

module controlWordGen (
    input  logic [ctrlPkg::stepW-1:0]      step,
    input  logic [ctrlPkg::aluOpW-1:0]     aluOp,
    input  logic                           useImm,
    input  logic [ctrlPkg::shiftCtrlW-1:0] shiftKind,
    input  logic                           shiftByReg,
    output logic                           pcWrite,
    output logic                           irWrite,
    output logic                           regWrite,
    output logic                           aWrite,
    output logic                           bWrite,
    output logic                           aluOutWrite,
    output logic [ctrlPkg::regDstW-1:0]    regDst,
    output logic [ctrlPkg::aluSrcAW-1:0]   aluSrcA,
    output logic [ctrlPkg::shamtSelW-1:0]  shamtSel,
    output logic                           shiftSrc,
    output logic [ctrlPkg::memToRegW-1:0]  memToReg,
    output logic [ctrlPkg::aluSrcBW-1:0]   aluSrcB,
    output logic [ctrlPkg::aluOpW-1:0]     aluOpOut,
    output logic [ctrlPkg::shiftCtrlW-1:0] shiftCtrl
);

    import ctrlPkg::*;

    // Shift amount comes from the instruction unless the shift is variable
    logic                 amountFromField;
    logic [shamtSelW-1:0] amountSel;

    assign amountFromField = ~shiftByReg;
    assign amountSel       = shiftByReg ? shamtRegB : shamtField;

    always_comb begin
        pcWrite     = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        aWrite      = 1'b0;
        bWrite      = 1'b0;
        aluOutWrite = 1'b0;
        regDst      = dstRt;
        aluSrcA     = srcAPc;
        shamtSel    = shamtField;
        shiftSrc    = 1'b0;
        memToReg    = wbAluOut;
        aluSrcB     = srcBRegB;
        aluOpOut    = aluOpNone;
        shiftCtrl   = shiftNone;

        case (step)
            stepFetch: begin
                aluSrcB  = srcBFour;
                aluOpOut = aluOpAdd;
            end
            stepPcUpdate: begin
                pcWrite  = 1'b1;
                aluSrcB  = srcBFour;
                aluOpOut = aluOpAdd;
            end
            stepIrLoad: begin
                irWrite = 1'b1;
                aluSrcB = srcBFour;
            end
            stepRegRead: begin
                // Branch target is computed speculatively here
                aWrite      = 1'b1;
                bWrite      = 1'b1;
                aluOutWrite = 1'b1;
                aluSrcB     = srcBBranch;
                aluOpOut    = aluOpAdd;
            end
            stepDispatch: begin
                aluOpOut = aluOpAdd;
            end
            stepExecAlu: begin
                aluOutWrite = 1'b1;
                aluSrcA     = srcARegA;
                aluSrcB     = useImm ? srcBImm : srcBRegB;
                aluOpOut    = aluOp;
            end
            stepWriteAlu: begin
                regWrite = 1'b1;
                regDst   = useImm ? dstRt : dstRd;
                memToReg = wbAluOut;
            end
            stepShiftLoad: begin
                shiftCtrl = shiftLoad;
                shiftSrc  = amountFromField;
                shamtSel  = amountSel;
            end
            stepShiftRun: begin
                shiftCtrl = shiftKind;
                shiftSrc  = amountFromField;
                shamtSel  = amountSel;
            end
            stepWriteShift: begin
                regWrite = 1'b1;
                regDst   = dstRd;
                memToReg = wbShift;
            end
            default: begin
                // Settle and retire leave everything idle
                shiftCtrl = shiftNone;
            end
        endcase
    end

    // Register file write and instruction load belong to different steps
    always_comb begin
        assert (!(regWrite && irWrite))
            else $error("regWrite and irWrite both high in step %0d", step);
    end

endmodule

`default_nettype wire

/* hdl/multicycleCtrl.sv */
`default_nettype none

module multicycleCtrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [ctrlPkg::fieldW-1:0]     opcode,
    input  logic [ctrlPkg::fieldW-1:0]     funct,
    output logic                           pcWrite,
    output logic                           irWrite,
    output logic                           regWrite,
    output logic                           aWrite,
    output logic                           bWrite,
    output logic                           aluOutWrite,
    output logic [ctrlPkg::regDstW-1:0]    regDst,
    output logic [ctrlPkg::aluSrcAW-1:0]   aluSrcA,
    output logic [ctrlPkg::shamtSelW-1:0]  shamtSel,
    output logic                           shiftSrc,
    output logic [ctrlPkg::memToRegW-1:0]  memToReg,
    output logic [ctrlPkg::aluSrcBW-1:0]   aluSrcB,
    output logic [ctrlPkg::aluOpW-1:0]     aluOp,
    output logic [ctrlPkg::shiftCtrlW-1:0] shiftCtrl
);

    import ctrlPkg::*;

    logic [pathW-1:0]      execPath;
    logic [aluOpW-1:0]     decAluOp;
    logic                  useImm;
    logic [shiftCtrlW-1:0] shiftKind;
    logic                  shiftByReg;
    logic [stepW-1:0]      step;

    instrDecoder decoder_i (
        .opcode    (opcode),
        .funct     (funct),
        .execPath  (execPath),
        .aluOp     (decAluOp),
        .useImm    (useImm),
        .shiftKind (shiftKind),
        .shiftByReg(shiftByReg)
    );

    stepSequencer sequencer_i (
        .clk     (clk),
        .reset   (reset),
        .execPath(execPath),
        .step    (step)
    );

    controlWordGen wordGen_i (
        .step       (step),
        .aluOp      (decAluOp),
        .useImm     (useImm),
        .shiftKind  (shiftKind),
        .shiftByReg (shiftByReg),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .aWrite     (aWrite),
        .bWrite     (bWrite),
        .aluOutWrite(aluOutWrite),
        .regDst     (regDst),
        .aluSrcA    (aluSrcA),
        .shamtSel   (shamtSel),
        .shiftSrc   (shiftSrc),
        .memToReg   (memToReg),
        .aluSrcB    (aluSrcB),
        .aluOpOut   (aluOp),
        .shiftCtrl  (shiftCtrl)
    );

endmodule

`default_nettype wire

/* verification/multicycleCtrlTb.sv */
`default_nettype none

module multicycleCtrlTb;

    import ctrlPkg::*;

    localparam int cyclesPerVector = 12;
    localparam int spareCycles     = 20;

    logic                  clk;
    logic                  reset;
    logic [fieldW-1:0]     opcode;
    logic [fieldW-1:0]     funct;
    logic                  pcWrite;
    logic                  irWrite;
    logic                  regWrite;
    logic                  aWrite;
    logic                  bWrite;
    logic                  aluOutWrite;
    logic [regDstW-1:0]    regDst;
    logic [aluSrcAW-1:0]   aluSrcA;
    logic [shamtSelW-1:0]  shamtSel;
    logic                  shiftSrc;
    logic [memToRegW-1:0]  memToReg;
    logic [aluSrcBW-1:0]   aluSrcB;
    logic [aluOpW-1:0]     aluOp;
    logic [shiftCtrlW-1:0] shiftCtrl;

    // One entry per line of the vector file
    string                 vecName[$];
    logic [fieldW-1:0]     vecOpcode[$];
    logic [fieldW-1:0]     vecFunct[$];
    int                    vecCycles[$];
    logic [aluOpW-1:0]     vecAluOp[$];
    logic [aluSrcBW-1:0]   vecSrcB[$];
    logic [shiftCtrlW-1:0] vecShift[$];
    logic [shamtSelW-1:0]  vecShamt[$];
    logic [regDstW-1:0]    vecRegDst[$];
    logic [memToRegW-1:0]  vecMemToReg[$];

    int    cycleCount;
    int    cycleLimit;
    int    testErrors;
    int    failedTests;
    int    totalErrors;
    string testName;

    multicycleCtrl dut_i (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .funct      (funct),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .aWrite     (aWrite),
        .bWrite     (bWrite),
        .aluOutWrite(aluOutWrite),
        .regDst     (regDst),
        .aluSrcA    (aluSrcA),
        .shamtSel   (shamtSel),
        .shiftSrc   (shiftSrc),
        .memToReg   (memToReg),
        .aluSrcB    (aluSrcB),
        .aluOp      (aluOp),
        .shiftCtrl  (shiftCtrl)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

    // Fetch is the only step with PC + 4 selected and no register loading
    function automatic logic atFetch();
        return aluSrcB == srcBFour && aluOp == aluOpAdd && !pcWrite && !irWrite;
    endfunction

    function automatic logic allIdle();
        return !(pcWrite | irWrite | regWrite | aWrite | bWrite | aluOutWrite | shiftSrc)
            && regDst == '0 && aluSrcA == '0 && shamtSel == '0 && memToReg == '0
            && aluSrcB == '0 && aluOp == '0 && shiftCtrl == '0;
    endfunction

    task automatic reportMismatch(string what, int expected, int actual);
        $display("FAIL %s %s: expected %0d, actual %0d", testName, what, expected, actual);
        testErrors++;
    endtask

    task automatic reportProblem(string what);
        $display("%s: %s", testName, what);
        testErrors++;
    endtask

    task automatic loadVectors();
        int                    fd;
        int                    fields;
        int                    cycles;
        string                 line;
        string                 name;
        logic [fieldW-1:0]     op;
        logic [fieldW-1:0]     fn;
        logic [aluOpW-1:0]     expAluOp;
        logic [aluSrcBW-1:0]   expSrcB;
        logic [shiftCtrlW-1:0] expShift;
        logic [shamtSelW-1:0]  expShamt;
        logic [regDstW-1:0]    expRegDst;
        logic [memToRegW-1:0]  expMemToReg;
        fd = $fopen("verification/ctrlVectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verification/ctrlVectors.txt for reading");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %h %d %h %h %h %h %h %h", name, op, fn, cycles,
                                 expAluOp, expSrcB, expShift, expShamt, expRegDst, expMemToReg);
                if (fields == 10) begin
                    vecName.push_back(name);
                    vecOpcode.push_back(op);
                    vecFunct.push_back(fn);
                    vecCycles.push_back(cycles);
                    vecAluOp.push_back(expAluOp);
                    vecSrcB.push_back(expSrcB);
                    vecShift.push_back(expShift);
                    vecShamt.push_back(expShamt);
                    vecRegDst.push_back(expRegDst);
                    vecMemToReg.push_back(expMemToReg);
                end
            end
        end
        $fclose(fd);
    endtask

    // Cycle 0 is fetch; 1 to 3 are the common steps, 4 is dispatch
    task automatic checkStep(int idx, int cycle, int writeCycle);
        logic fieldShift;
        fieldShift = (vecShamt[idx] == shamtField);
        if (pcWrite !== (cycle == 1))
            reportMismatch("pcWrite", int'(cycle == 1), int'(pcWrite));
        if (irWrite !== (cycle == 2))
            reportMismatch("irWrite", int'(cycle == 2), int'(irWrite));
        if (regWrite !== (cycle == writeCycle))
            reportMismatch("regWrite", int'(cycle == writeCycle), int'(regWrite));
        if (cycle == 3 && (aWrite & bWrite & aluOutWrite) !== 1'b1)
            reportProblem("register read did not load A, B and ALUOut together");
        if (vecCycles[idx] == 8 && cycle == 5) begin
            if (aluSrcA !== srcARegA)
                reportMismatch("aluSrcA", int'(srcARegA), int'(aluSrcA));
            if (aluSrcB !== vecSrcB[idx])
                reportMismatch("aluSrcB", int'(vecSrcB[idx]), int'(aluSrcB));
            if (aluOp !== vecAluOp[idx])
                reportMismatch("aluOp", int'(vecAluOp[idx]), int'(aluOp));
        end
        if (vecCycles[idx] == 10 && (cycle == 5 || cycle == 6)) begin
            if (shamtSel !== vecShamt[idx])
                reportMismatch("shamtSel", int'(vecShamt[idx]), int'(shamtSel));
            if (shiftSrc !== fieldShift)
                reportMismatch("shiftSrc", int'(fieldShift), int'(shiftSrc));
            if (cycle == 5 && shiftCtrl !== shiftLoad)
                reportMismatch("shiftCtrl load", int'(shiftLoad), int'(shiftCtrl));
            if (cycle == 6 && shiftCtrl !== vecShift[idx])
                reportMismatch("shiftCtrl run", int'(vecShift[idx]), int'(shiftCtrl));
        end
        if (cycle == writeCycle) begin
            if (regDst !== vecRegDst[idx])
                reportMismatch("regDst", int'(vecRegDst[idx]), int'(regDst));
            if (memToReg !== vecMemToReg[idx])
                reportMismatch("memToReg", int'(vecMemToReg[idx]), int'(memToReg));
        end
    endtask

    task automatic waitForFetch();
        @(negedge clk);
        while (!atFetch()) begin
            @(negedge clk);
        end
    endtask

    // Entered with the DUT in fetch, returns at the next fetch
    task automatic runVector(int idx);
        int   cycle;
        int   writeCycle;
        logic done;
        logic wasIdle;
        testName   = vecName[idx];
        testErrors = 0;
        cycle      = 0;
        done       = 1'b0;
        wasIdle    = 1'b0;
        writeCycle = (vecCycles[idx] == 8) ? 6 : (vecCycles[idx] == 10) ? 8 : -1;
        @(posedge clk);
        opcode <= vecOpcode[idx];
        funct  <= vecFunct[idx];
        while (!done) begin
            @(negedge clk);
            cycle++;
            if (atFetch()) begin
                done = 1'b1;
                if (!wasIdle)
                    reportProblem("fetch was not preceded by an idle retire step");
                if (regWrite || aWrite || bWrite || aluOutWrite)
                    reportProblem("a write enable was high during fetch");
            end else begin
                checkStep(idx, cycle, writeCycle);
                wasIdle = allIdle();
            end
        end
        if (cycle != vecCycles[idx])
            reportMismatch("cycle count", vecCycles[idx], cycle);
        if (testErrors == 0) begin
            $display("PASS %s: expected %0d cycles, actual %0d", testName, vecCycles[idx], cycle);
        end else begin
            $display("FAIL %s: expected %0d cycles, actual %0d, %0d mismatches",
                     testName, vecCycles[idx], cycle, testErrors);
            failedTests++;
        end
        totalErrors += testErrors;
    endtask

    initial begin
        clk         = 1'b0;
        cycleCount  = 0;
        cycleLimit  = 0;
        testErrors  = 0;
        failedTests = 0;
        totalErrors = 0;
        testName    = "reset";
        reset  <= 1'b1;
        opcode <= '0;
        funct  <= '0;
        loadVectors();
        cycleLimit = cyclesPerVector * vecName.size() + spareCycles;
        if (vecName.size() == 0) begin
            $display("The vector file held no usable test lines");
            totalErrors++;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        waitForFetch();
        foreach (vecName[i]) begin
            runVector(i);
        end
        $display("Tests: %0d, failed: %0d, mismatches: %0d",
                 vecName.size(), failedTests, totalErrors);
        if (totalErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/ctrlVectors.txt */
# name opcode funct cycles aluOp aluSrcB shiftCtrl shamtSel regDst memToReg
# opcode, funct and the control fields in hex, cycles in decimal
add       00 20  8 1 0 0 0 3 0
sub       00 22  8 2 0 0 0 3 0
and       00 24  8 3 0 0 0 3 0
addi      08 20  8 1 3 0 0 0 0
addiOnes  08 3f  8 1 3 0 0 0 0
sll       00 00 10 0 0 2 0 3 2
srl       00 02 10 0 0 3 0 3 2
sra       00 03 10 0 0 4 0 3 2
sllv      00 04 10 0 0 2 3 3 2
srav      00 07 10 0 0 4 3 3 2
srlv      00 06  6 0 0 0 0 0 0
slt       00 2a  6 0 0 0 0 0 0
lw        23 00  6 0 0 0 0 0 0
jump      02 00  6 0 0 0 0 0 0
addAgain  00 20  8 1 0 0 0 3 0
srlAgain  00 02 10 0 0 3 0 3 2

/* list.f */
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/stepSequencer.sv
hdl/controlWordGen.sv
hdl/multicycleCtrl.sv
verification/multicycleCtrlTb.sv

/* Makefile */
# Verilator build and run of the multicycle control unit testbench

VERILATOR ?= verilator
TOP       ?= multicycleCtrlTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= No errors

SOURCES := $(wildcard hdl/*.sv verification/*.sv) verification/ctrlVectors.txt

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
